//--- common/ahb_pkg.sv
package ahb_pkg;

    // htrans encodings
    typedef logic [1:0] htrans_t;
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // only byte and halfword transfers on the 16-bit bus
    typedef logic hsize_t;
    localparam hsize_t SIZE_BYTE = 1'b0;
    localparam hsize_t SIZE_HALF = 1'b1;

    // register map, two byte addresses per 16-bit register
    typedef logic [3:0] haddr_t;
    localparam haddr_t ADDR_STATUS_LO  = 4'd0;
    localparam haddr_t ADDR_STATUS_HI  = 4'd1;
    localparam haddr_t ADDR_RESULT_LO  = 4'd2;
    localparam haddr_t ADDR_RESULT_HI  = 4'd3;
    localparam haddr_t ADDR_SAMPLE_LO  = 4'd4;
    localparam haddr_t ADDR_SAMPLE_HI  = 4'd5;
    localparam haddr_t ADDR_COEFF_BASE = 4'd6;
    localparam haddr_t ADDR_NEW_COEFF  = 4'd14;

    // status word bit positions
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_ERR_BIT  = 8;

endpackage

//--- common/fir_pkg.sv
package fir_pkg;

    // number of filter taps, also the coefficient table depth
    localparam int NUM_TAPS = 4;

    // unsigned 16-bit word for samples, coefficients and results
    typedef logic [15:0] sample_t;

    // selects one of the four taps
    typedef logic [1:0] coeff_idx_t;

    // four 32-bit products summed without loss
    typedef logic [33:0] acc_t;

    // result is taken from bits 31:16 of the sum
    localparam int RESULT_LSB = 16;

endpackage

//--- compile.f
common/ahb_pkg.sv
common/fir_pkg.sv
design/ahb_lite_slave.sv
design/coefficient_loader.sv
fir_filter/fir_controller.sv
fir_filter/fir_datapath.sv
design/ahb_lite_fir_filter.sv
dv/tb_ahb_lite_fir_filter.sv

//--- design/ahb_lite_fir_filter.sv
`timescale 1ns/1ns

module ahb_lite_fir_filter (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             hsel,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::hsize_t  hsize,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  logic [15:0]      hwdata,
    output logic [15:0]      hrdata,
    output logic             hresp
);

    import fir_pkg::*;

    // slave to filter
    sample_t    sample_data;
    sample_t    fir_coefficient;
    logic       data_ready;
    logic       new_coefficient_set;

    // loader
    coeff_idx_t coefficient_num;
    logic       load_coeff;
    logic       load_done;

    // controller to datapath
    logic       modwait;
    logic       shift_sample;
    logic       mac_en;
    coeff_idx_t tap_sel;
    logic       store_result;

    sample_t    fir_out;
    logic       err;

    ahb_lite_slave u_slave (
        .clk                 (clk),
        .n_rst               (n_rst),
        .hsel                (hsel),
        .haddr               (haddr),
        .hsize               (hsize),
        .htrans              (htrans),
        .hwrite              (hwrite),
        .hwdata              (hwdata),
        .modwait             (modwait),
        .fir_out             (fir_out),
        .err                 (err),
        .coefficient_num     (coefficient_num),
        .load_done           (load_done),
        .hrdata              (hrdata),
        .hresp               (hresp),
        .sample_data         (sample_data),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .fir_coefficient     (fir_coefficient)
    );

    coefficient_loader u_loader (
        .clk                 (clk),
        .n_rst               (n_rst),
        .new_coefficient_set (new_coefficient_set),
        .modwait             (modwait),
        .coefficient_num     (coefficient_num),
        .load_coeff          (load_coeff),
        .load_done           (load_done)
    );

    fir_controller u_controller (
        .clk          (clk),
        .n_rst        (n_rst),
        .data_ready   (data_ready),
        .load_coeff   (load_coeff),
        .modwait      (modwait),
        .shift_sample (shift_sample),
        .mac_en       (mac_en),
        .tap_sel      (tap_sel),
        .store_result (store_result)
    );

    fir_datapath u_datapath (
        .clk             (clk),
        .n_rst           (n_rst),
        .sample_data     (sample_data),
        .fir_coefficient (fir_coefficient),
        .coefficient_num (coefficient_num),
        .load_coeff      (load_coeff),
        .shift_sample    (shift_sample),
        .mac_en          (mac_en),
        .tap_sel         (tap_sel),
        .store_result    (store_result),
        .fir_out         (fir_out),
        .err             (err)
    );

endmodule

//--- design/ahb_lite_slave.sv
`timescale 1ns/1ns

module ahb_lite_slave (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                hsel,
    input  ahb_pkg::haddr_t     haddr,
    input  ahb_pkg::hsize_t     hsize,
    input  ahb_pkg::htrans_t    htrans,
    input  logic                hwrite,
    input  logic [15:0]         hwdata,
    input  logic                modwait,
    input  fir_pkg::sample_t    fir_out,
    input  logic                err,
    input  fir_pkg::coeff_idx_t coefficient_num,
    input  logic                load_done,
    output logic [15:0]         hrdata,
    output logic                hresp,
    output fir_pkg::sample_t    sample_data,
    output logic                data_ready,
    output logic                new_coefficient_set,
    output fir_pkg::sample_t    fir_coefficient
);

    import ahb_pkg::*;
    import fir_pkg::*;

    // address phase, held for the data phase
    logic    sel_q;
    haddr_t  addr_q;
    hsize_t  size_q;
    htrans_t trans_q;
    logic    write_q;

    sample_t coeff_table [NUM_TAPS];

    logic       xfer_active;
    logic       wr_en;
    logic       rd_en;
    logic       upper_lane;
    logic       is_sample;
    logic       is_coeff;
    haddr_t     coeff_offset;
    coeff_idx_t coeff_sel;
    sample_t    status_word;
    sample_t    wr_sample;
    sample_t    wr_coeff;

    // byte writes only touch the lane picked by the low address bit
    function automatic sample_t merge_lanes(
        sample_t     old_value,
        logic [15:0] wdata,
        hsize_t      size,
        logic        upper
    );
        sample_t merged;
        merged = old_value;
        if (size == SIZE_HALF) begin
            merged = wdata;
        end else if (upper) begin
            merged[15:8] = wdata[15:8];
        end else begin
            merged[7:0] = wdata[7:0];
        end
        return merged;
    endfunction

    // byte reads return their lane, the other lane reads zero
    function automatic logic [15:0] read_lanes(sample_t value, hsize_t size, logic upper);
        logic [15:0] lanes;
        lanes = value;
        if (size == SIZE_BYTE) begin
            lanes = upper ? {value[15:8], 8'h00} : {8'h00, value[7:0]};
        end
        return lanes;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sel_q   <= 1'b0;
            addr_q  <= '0;
            size_q  <= SIZE_BYTE;
            trans_q <= HTRANS_IDLE;
            write_q <= 1'b0;
        end else begin
            sel_q   <= hsel;
            addr_q  <= haddr;
            size_q  <= hsize;
            trans_q <= htrans;
            write_q <= hwrite;
        end
    end

    // idle and busy transfers get no data phase
    assign xfer_active = sel_q && (trans_q == HTRANS_NONSEQ || trans_q == HTRANS_SEQ);
    assign wr_en = xfer_active && write_q;
    assign rd_en = xfer_active && !write_q;
    assign upper_lane = addr_q[0];

    assign is_sample = (addr_q == ADDR_SAMPLE_LO) || (addr_q == ADDR_SAMPLE_HI);
    assign is_coeff = (addr_q >= ADDR_COEFF_BASE) && (addr_q < ADDR_NEW_COEFF);
    assign coeff_offset = addr_q - ADDR_COEFF_BASE;
    assign coeff_sel = coeff_offset[2:1];

    // status and result are read-only
    assign hresp = wr_en && (addr_q <= ADDR_RESULT_HI);

    assign wr_sample = merge_lanes(sample_data, hwdata, size_q, upper_lane);
    assign wr_coeff = merge_lanes(coeff_table[coeff_sel], hwdata, size_q, upper_lane);

    // busy covers a pending coefficient load as well as a running sample
    always_comb begin
        status_word = '0;
        status_word[STATUS_BUSY_BIT] = new_coefficient_set || modwait;
        status_word[STATUS_ERR_BIT] = err;
    end

    always_comb begin
        hrdata = '0;
        if (rd_en) begin
            case (addr_q)
                ADDR_STATUS_LO, ADDR_STATUS_HI: begin
                    hrdata = read_lanes(status_word, size_q, upper_lane);
                end
                ADDR_RESULT_LO, ADDR_RESULT_HI: begin
                    hrdata = read_lanes(fir_out, size_q, upper_lane);
                end
                ADDR_SAMPLE_LO, ADDR_SAMPLE_HI: begin
                    hrdata = read_lanes(sample_data, size_q, upper_lane);
                end
                ADDR_NEW_COEFF: begin
                    hrdata = {15'd0, new_coefficient_set};
                end
                default: begin
                    if (is_coeff) begin
                        hrdata = read_lanes(coeff_table[coeff_sel], size_q, upper_lane);
                    end
                end
            endcase
        end
    end

    // loader picks its entry in the same cycle
    assign fir_coefficient = coeff_table[coefficient_num];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coeff_table[i] <= '0;
            end
        end else if (wr_en && is_coeff) begin
            coeff_table[coeff_sel] <= wr_coeff;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sample_data         <= '0;
            data_ready          <= 1'b0;
            new_coefficient_set <= 1'b0;
        end else begin
            if (wr_en && is_sample) begin
                sample_data <= wr_sample;
            end
            // only a full halfword write starts the filter
            if (wr_en && is_sample && size_q == SIZE_HALF) begin
                data_ready <= 1'b1;
            end else if (data_ready && !modwait && !new_coefficient_set) begin
                // controller takes the sample now, modwait rises next cycle
                data_ready <= 1'b0;
            end
            if (wr_en && addr_q == ADDR_NEW_COEFF) begin
                new_coefficient_set <= hwdata[0];
            end else if (load_done) begin
                new_coefficient_set <= 1'b0;
            end
        end
    end

endmodule

//--- design/coefficient_loader.sv
`timescale 1ns/1ns

module coefficient_loader (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                new_coefficient_set,
    input  logic                modwait,
    output fir_pkg::coeff_idx_t coefficient_num,
    output logic                load_coeff,
    output logic                load_done
);

    import fir_pkg::*;

    logic       active;
    logic       start;
    logic       last;
    coeff_idx_t count;

    // begin only between samples so taps never change mid computation
    assign start = !active && new_coefficient_set && !modwait;
    assign last = (count == coeff_idx_t'(NUM_TAPS - 1));

    // first step goes out in the start cycle
    assign load_coeff = start || active;
    assign load_done = load_coeff && last;
    assign coefficient_num = count;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            active <= 1'b0;
            count  <= '0;
        end else if (load_coeff) begin
            // wraps back to tap 0 after the last step
            count  <= count + 2'd1;
            active <= !last;
        end
    end

endmodule

//--- dv/tb_ahb_lite_fir_filter.sv
`timescale 1ns/1ns

module tb_ahb_lite_fir_filter;

    import ahb_pkg::*;
    import fir_pkg::*;

    localparam int POLL_LIMIT = 40;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        hsel;
    haddr_t      haddr;
    hsize_t      hsize;
    htrans_t     htrans;
    logic        hwrite;
    logic [15:0] hwdata;
    logic [15:0] hrdata;
    logic        hresp;

    integer seed = 15;
    int     error_count = 0;

    // model state and the next coefficient set to load
    sample_t model_coeff [NUM_TAPS];
    sample_t model_taps [NUM_TAPS];
    sample_t new_coeff [NUM_TAPS];

    // observations waiting for the comparator
    string       name_q [$];
    time         time_q [$];
    logic [15:0] actual_q [$];
    logic [15:0] expected_q [$];

    ahb_lite_fir_filter DUT (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input time at, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s = 0x%04h, expected 0x%04h", at, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic queue_compare(input string name, input logic [15:0] actual,
                                 input logic [15:0] expected);
        name_q.push_back(name);
        time_q.push_back($time);
        actual_q.push_back(actual);
        expected_q.push_back(expected);
    endtask

    // observations are pushed on falling edges and compared on rising edges
    always @(posedge clk) begin
        while (name_q.size() != 0) begin
            check(name_q[0], time_q[0], actual_q[0], expected_q[0]);
            name_q.delete(0);
            time_q.delete(0);
            actual_q.delete(0);
            expected_q.delete(0);
        end
    end

    // shifts the sample into the model and returns {err, result}
    function automatic logic [16:0] fir_ref(input sample_t new_sample);
        logic [33:0] sum;
        logic [31:0] prod;
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            model_taps[i] = model_taps[i-1];
        end
        model_taps[0] = new_sample;
        sum = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod = {16'd0, model_coeff[i]} * {16'd0, model_taps[i]};
            sum = sum + {2'b00, prod};
        end
        return {sum >= (34'd1 << 32), sum[31:16]};
    endfunction

    function automatic haddr_t coeff_addr(input int idx);
        return ADDR_COEFF_BASE + haddr_t'(2 * idx);
    endfunction

    // starts on a falling edge and returns on the one after the data phase
    task automatic bus_write(input haddr_t addr, input hsize_t size, input logic [15:0] data);
        hsel = 1'b1;
        haddr = addr;
        hsize = size;
        htrans = HTRANS_NONSEQ;
        hwrite = 1'b1;
        @(negedge clk);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = data;
        // status and result are read-only
        queue_compare("hresp", {15'd0, hresp}, {15'd0, addr <= ADDR_RESULT_HI});
        @(negedge clk);
        queue_compare("hresp after data phase", {15'd0, hresp}, 16'd0);
    endtask

    task automatic bus_read(input haddr_t addr, output logic [15:0] data);
        hsel = 1'b1;
        haddr = addr;
        hsize = SIZE_HALF;
        htrans = HTRANS_NONSEQ;
        hwrite = 1'b0;
        @(negedge clk);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        data = hrdata;
        queue_compare("hresp", {15'd0, hresp}, 16'd0);
    endtask

    task automatic read_expect(input haddr_t addr, input logic [15:0] expected,
                               input string name);
        logic [15:0] data;
        bus_read(addr, data);
        queue_compare(name, data, expected);
    endtask

    task automatic wait_idle();
        logic [15:0] status;
        int          polls;
        polls = 0;
        bus_read(ADDR_STATUS_LO, status);
        while (status[STATUS_BUSY_BIT] && polls < POLL_LIMIT) begin
            polls++;
            bus_read(ADDR_STATUS_LO, status);
        end
        if (status[STATUS_BUSY_BIT]) begin
            $display("timeout: status busy bit never cleared");
            abort_run();
        end
    endtask

    task automatic wait_flag_clear();
        logic [15:0] flag;
        int          polls;
        polls = 0;
        bus_read(ADDR_NEW_COEFF, flag);
        while (flag[0] && polls < POLL_LIMIT) begin
            polls++;
            bus_read(ADDR_NEW_COEFF, flag);
        end
        if (flag[0]) begin
            $display("timeout: new coefficient flag never cleared");
            abort_run();
        end
    endtask

    // writes new_coeff into the table and has the loader copy it
    task automatic load_coeffs();
        for (int i = 0; i < NUM_TAPS; i++) begin
            bus_write(coeff_addr(i), SIZE_HALF, new_coeff[i]);
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_expect(coeff_addr(i), new_coeff[i], $sformatf("coefficient F%0d", i));
        end
        bus_write(ADDR_NEW_COEFF, SIZE_HALF, 16'h0001);
        read_expect(ADDR_NEW_COEFF, 16'h0001, "new coefficient flag");
        wait_flag_clear();
        wait_idle();
        for (int i = 0; i < NUM_TAPS; i++) begin
            model_coeff[i] = new_coeff[i];
        end
    endtask

    task automatic run_sample(input sample_t sample);
        logic [16:0] expected;
        logic [15:0] status_exp;
        bus_write(ADDR_SAMPLE_LO, SIZE_HALF, sample);
        expected = fir_ref(sample);
        wait_idle();
        status_exp = '0;
        status_exp[STATUS_ERR_BIT] = expected[16];
        read_expect(ADDR_RESULT_LO, expected[15:0], "fir_out");
        read_expect(ADDR_STATUS_LO, status_exp, "status");
        read_expect(ADDR_SAMPLE_LO, sample, "sample register");
    endtask

    initial begin
        logic [31:0] rnd;
        int          polls;
        n_rst = 1'b0;
        hsel = 1'b0;
        haddr = '0;
        hsize = SIZE_BYTE;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            model_coeff[i] = '0;
            model_taps[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // registers after reset
        read_expect(ADDR_STATUS_LO, 16'h0000, "status");
        read_expect(ADDR_RESULT_LO, 16'h0000, "fir_out");
        read_expect(ADDR_SAMPLE_LO, 16'h0000, "sample register");
        read_expect(ADDR_NEW_COEFF, 16'h0000, "new coefficient flag");

        // read-only registers answer with an error
        for (int a = 0; a <= int'(ADDR_RESULT_HI); a++) begin
            bus_write(haddr_t'(a), SIZE_HALF, 16'hFFFF);
        end
        read_expect(ADDR_STATUS_LO, 16'h0000, "status");
        read_expect(ADDR_RESULT_LO, 16'h0000, "fir_out");

        // halfword and byte lanes while the filter coefficients are still zero
        run_sample(16'h1234);
        bus_write(ADDR_SAMPLE_HI, SIZE_BYTE, 16'hABFF);
        read_expect(ADDR_SAMPLE_LO, 16'hAB34, "sample register");
        bus_write(ADDR_SAMPLE_LO, SIZE_BYTE, 16'hEECD);
        read_expect(ADDR_SAMPLE_LO, 16'hABCD, "sample register");
        bus_write(coeff_addr(1), SIZE_HALF, 16'h5A5A);
        bus_write(coeff_addr(1) + 4'd1, SIZE_BYTE, 16'h3CFF);
        read_expect(coeff_addr(1), 16'h3C5A, "coefficient F1");
        bus_write(coeff_addr(1), SIZE_BYTE, 16'hFFC3);
        read_expect(coeff_addr(1), 16'h3CC3, "coefficient F1");
        bus_write(coeff_addr(3), SIZE_HALF, 16'hBEEF);
        read_expect(coeff_addr(3), 16'hBEEF, "coefficient F3");

        // first set with two large taps to drive the sum past 2^32
        for (int i = 0; i < NUM_TAPS; i++) begin
            rnd = $random(seed);
            new_coeff[i] = (i < 2) ? (rnd[15:0] | 16'h8000) : rnd[15:0];
        end
        load_coeffs();
        for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            run_sample(rnd[15:0]);
        end

        // second set mid-stream while the delay line keeps its samples
        for (int i = 0; i < NUM_TAPS; i++) begin
            rnd = $random(seed);
            new_coeff[i] = rnd[15:0] & 16'h3FFF;
        end
        load_coeffs();
        for (int n = 0; n < 10; n++) begin
            rnd = $random(seed);
            run_sample(rnd[15:0]);
        end

        polls = 0;
        while (name_q.size() != 0 && polls < POLL_LIMIT) begin
            @(negedge clk);
            polls++;
        end
        if (name_q.size() != 0) begin
            $display("timeout: comparisons still pending at the end of the run");
            abort_run();
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- fir_filter/fir_controller.sv
`timescale 1ns/1ns

module fir_controller (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                data_ready,
    input  logic                load_coeff,
    output logic                modwait,
    output logic                shift_sample,
    output logic                mac_en,
    output fir_pkg::coeff_idx_t tap_sel,
    output logic                store_result
);

    import fir_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        STORE
    } state_t;

    state_t state;
    state_t state_next;
    logic   start;
    logic   last_tap;

    // a coefficient load in progress holds off new samples
    assign start = (state == IDLE) && data_ready && !modwait && !load_coeff;
    assign last_tap = (tap_sel == coeff_idx_t'(NUM_TAPS - 1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = ACCUM;
                end
            end
            ACCUM: begin
                if (last_tap) begin
                    state_next = STORE;
                end
            end
            STORE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= IDLE;
            tap_sel <= '0;
            modwait <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                tap_sel <= '0;
            end else if (mac_en) begin
                tap_sel <= tap_sel + 2'd1;
            end
            // high through the computation and any coefficient load
            modwait <= (state_next != IDLE) || load_coeff;
        end
    end

    // sample shifts in as the FSM leaves idle
    assign shift_sample = start;
    assign mac_en = (state == ACCUM);
    assign store_result = (state == STORE);

endmodule

//--- fir_filter/fir_datapath.sv
`timescale 1ns/1ns

module fir_datapath (
    input  logic                clk,
    input  logic                n_rst,
    input  fir_pkg::sample_t    sample_data,
    input  fir_pkg::sample_t    fir_coefficient,
    input  fir_pkg::coeff_idx_t coefficient_num,
    input  logic                load_coeff,
    input  logic                shift_sample,
    input  logic                mac_en,
    input  fir_pkg::coeff_idx_t tap_sel,
    input  logic                store_result,
    output fir_pkg::sample_t    fir_out,
    output logic                err
);

    import fir_pkg::*;

    localparam int PROD_W = 2 * $bits(sample_t);

    sample_t           coeff [NUM_TAPS];
    sample_t           taps [NUM_TAPS];
    acc_t              acc;
    logic [PROD_W-1:0] product;

    // one tap per cycle through a single multiplier
    assign product = coeff[tap_sel] * taps[tap_sel];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coeff[i] <= '0;
                taps[i]  <= '0;
            end
        end else begin
            if (load_coeff) begin
                coeff[coefficient_num] <= fir_coefficient;
            end
            // newest sample at position 0
            if (shift_sample) begin
                taps[0] <= sample_data;
                for (int i = 1; i < NUM_TAPS; i++) begin
                    taps[i] <= taps[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift_sample) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc + acc_t'(product);
        end
    end

    // overflow when the sum reaches 2^32
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            fir_out <= '0;
            err     <= 1'b0;
        end else if (store_result) begin
            fir_out <= acc[RESULT_LSB +: $bits(sample_t)];
            err     <= |acc[$bits(acc_t)-1:PROD_W];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ahb_lite_fir_filter -f compile.f
./obj_dir/Vtb_ahb_lite_fir_filter > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
